// File: src/board_pkg.sv
// Board front-end constants; DBC_CYCLES is a simulation value and real keys need far more
package board_pkg;

  // ========================================
  // Push buttons
  // ========================================

  // Keys are active low on the board
  localparam int unsigned NUM_KEYS  = 4;
  localparam int unsigned KEY_GO    = 0;
  localparam int unsigned KEY_STOP  = 1;
  localparam int unsigned KEY_MODE  = 2;
  localparam int unsigned KEY_RESET = 3;

  // Cycles a new key level must hold
  localparam int unsigned DBC_CYCLES = 8;
  // Counter reaches DBC_CYCLES-1 at most
  localparam int unsigned DBC_CNT_W  = $clog2(DBC_CYCLES + 1);

  // ========================================
  // Run control widths
  // ========================================

  // Slide switches double as boot PC
  localparam int unsigned SW_W      = 10;
  // Run counter wraps
  localparam int unsigned RUN_CNT_W = 8;
  // Cycle timer saturates
  localparam int unsigned TIMER_W   = 24;

  // ========================================
  // Seven-segment display
  // ========================================

  localparam int unsigned NUM_DIGITS = 6;
  localparam int unsigned SEG_W      = 7;

  // Display mode codes
  localparam logic DISP_PC_COUNT = 1'b0;
  localparam logic DISP_TIMER    = 1'b1;

  // Segment bit 0 is a, bit 6 is g, active low
  localparam logic [SEG_W-1:0] SEG_ZERO  = 7'b1000000;
  localparam logic [SEG_W-1:0] SEG_BLANK = 7'b1111111;
  // Lower case r lights e and g
  localparam logic [SEG_W-1:0] SEG_R     = 7'b0101111;

endpackage : board_pkg

// File: src/key_debouncer.sv
// Key idles high; CYCLES must be at least 1 and fit the package counter width DBC_CNT_W
module key_debouncer #(
  parameter int unsigned CYCLES = board_pkg::DBC_CYCLES
) (
  input  logic clk,
  input  logic arst_n,
  input  logic key_raw,
  output logic level,
  output logic rise,
  output logic fall
);
  import board_pkg::*;

  // Two-stage synchronizer
  logic                 sync_q1;
  logic                 sync_q2;

  // Stability tracking
  logic [DBC_CNT_W-1:0] stable_cnt;
  logic                 differs;
  logic                 settle;

  // Synced value disagrees with the debounced level
  assign differs = (sync_q2 != level);
  // Last cycle of a full stable run
  assign settle  = differs && (stable_cnt == DBC_CNT_W'(CYCLES - 1));

  // ========================================
  // Synchronizer
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Released key reads high
      sync_q1 <= 1'b1;
      sync_q2 <= 1'b1;
    end else begin
      sync_q1 <= key_raw;
      sync_q2 <= sync_q1;
    end
  end

  // ========================================
  // Stability counter
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stable_cnt <= '0;
    end else if (!differs || settle) begin
      // Glitch ended or level about to flip
      stable_cnt <= '0;
    end else begin
      stable_cnt <= stable_cnt + 1'b1;
    end
  end

  // ========================================
  // Debounced level and edge strobes
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level <= 1'b1;
      rise  <= 1'b0;
      fall  <= 1'b0;
    end else begin
      if (settle) begin
        level <= sync_q2;
      end
      // Strobes land in the same cycle as the new level
      rise <= settle && sync_q2;
      fall <= settle && !sync_q2;
    end
  end

endmodule : key_debouncer

// File: src/reset_cond.sv
// Inputs are sampled on clk so pll_locked must be stable or synced; only arst_n acts asynchronously
module reset_cond (
  input  logic clk,
  input  logic arst_n,
  input  logic btn_level,
  input  logic pll_locked,
  output logic sys_rst_n
);

  // Both sources must be good before release
  logic       rst_ok;
  // Release shift chain, bit 1 is the output
  logic [1:0] rel_sync;

  // Debounced button is high when released
  assign rst_ok = btn_level & pll_locked;

  // ========================================
  // Release synchronizer
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Board reset asserts immediately
      rel_sync <= 2'b00;
    end else if (!rst_ok) begin
      // Button or lock loss asserts on the next edge
      rel_sync <= 2'b00;
    end else begin
      // Ones walk in, two edges to release
      rel_sync <= {rel_sync[0], 1'b1};
    end
  end

  // Registered output, no combinational path from inputs
  assign sys_rst_n = rel_sync[1];

endmodule : reset_cond

// File: src/run_ctrl_regs.sv
// Requests are one-cycle strobes; stop beats go in the same cycle and sys_rst_n does not clear this block
module run_ctrl_regs (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [board_pkg::SW_W-1:0]      sw,
  input  logic                            go_req,
  input  logic                            stop_req,
  input  logic                            mode_req,
  output logic                            go,
  output logic                            running,
  output logic [board_pkg::SW_W-1:0]      boot_pc,
  output logic [board_pkg::RUN_CNT_W-1:0] run_count,
  output logic [board_pkg::TIMER_W-1:0]   run_timer,
  output logic                            disp_mode
);
  import board_pkg::*;

  // Go that is not overridden by stop
  logic go_take;
  // Timer is at its ceiling
  logic timer_full;

  assign go_take    = go_req && !stop_req;
  assign timer_full = &run_timer;

  // ========================================
  // Run control
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      go        <= 1'b0;
      running   <= 1'b0;
      run_count <= '0;
    end else begin
      // Single-cycle start pulse to the processor
      go <= go_take;

      // Stop has priority
      if (stop_req) begin
        running <= 1'b0;
      end else if (go_take) begin
        running <= 1'b1;
      end

      // Count wraps past all ones
      if (go_take) begin
        run_count <= run_count + 1'b1;
      end
    end
  end

  // Boot PC snapshot of the switches at go
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      boot_pc <= '0;
    end else if (go_take) begin
      boot_pc <= sw;
    end
  end

  // ========================================
  // Run cycle timer
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_timer <= '0;
    end else if (go_take) begin
      // Fresh run starts at zero
      run_timer <= '0;
    end else if (running && !timer_full) begin
      // Saturate, never wrap
      run_timer <= run_timer + 1'b1;
    end
  end

  // Display mode toggle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      disp_mode <= DISP_PC_COUNT;
    end else if (mode_req) begin
      disp_mode <= (disp_mode == DISP_PC_COUNT) ? DISP_TIMER : DISP_PC_COUNT;
    end
  end

endmodule : run_ctrl_regs

// File: src/hex_display.sv
// Segments are active low with bit 0 as segment a and lag their inputs by one registered cycle
module hex_display (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            disp_mode,
  input  logic                            running,
  input  logic [board_pkg::SW_W-1:0]      boot_pc,
  input  logic [board_pkg::RUN_CNT_W-1:0] run_count,
  input  logic [board_pkg::TIMER_W-1:0]   run_timer,
  output logic [board_pkg::SEG_W-1:0]     hex0,
  output logic [board_pkg::SEG_W-1:0]     hex1,
  output logic [board_pkg::SEG_W-1:0]     hex2,
  output logic [board_pkg::SEG_W-1:0]     hex3,
  output logic [board_pkg::SEG_W-1:0]     hex4,
  output logic [board_pkg::SEG_W-1:0]     hex5
);
  import board_pkg::*;

  // Packed nibbles, digit 0 in the low bits
  logic [NUM_DIGITS*4-1:0] disp_word;
  // Boot PC padded to three digits
  logic [11:0]             pc_ext;
  logic [SEG_W-1:0]        seg_next [NUM_DIGITS];
  logic [SEG_W-1:0]        seg_q    [NUM_DIGITS];

  // Hex nibble to active-low segments
  function automatic logic [SEG_W-1:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_to_seg = 7'b1000000;
      4'h1: hex_to_seg = 7'b1111001;
      4'h2: hex_to_seg = 7'b0100100;
      4'h3: hex_to_seg = 7'b0110000;
      4'h4: hex_to_seg = 7'b0011001;
      4'h5: hex_to_seg = 7'b0010010;
      4'h6: hex_to_seg = 7'b0000010;
      4'h7: hex_to_seg = 7'b1111000;
      4'h8: hex_to_seg = 7'b0000000;
      4'h9: hex_to_seg = 7'b0010000;
      4'hA: hex_to_seg = 7'b0001000;
      4'hB: hex_to_seg = 7'b0000011;
      4'hC: hex_to_seg = 7'b1000110;
      4'hD: hex_to_seg = 7'b0100001;
      4'hE: hex_to_seg = 7'b0000110;
      4'hF: hex_to_seg = 7'b0001110;
    endcase
  endfunction

  assign pc_ext = 12'(boot_pc);

  // ========================================
  // Word select and encode
  // ========================================

  always_comb begin
    if (disp_mode == DISP_TIMER) begin
      disp_word = run_timer;
    end else begin
      // Count on hex5..4, status slot on hex3, PC on hex2..0
      disp_word = {run_count, 4'h0, pc_ext};
    end
    for (int i = 0; i < NUM_DIGITS; i++) begin
      seg_next[i] = hex_to_seg(disp_word[4*i +: 4]);
    end
    // Hex3 is the run status letter in PC mode
    if (disp_mode == DISP_PC_COUNT) begin
      seg_next[3] = running ? SEG_R : SEG_BLANK;
    end
  end

  // Output registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_DIGITS; i++) begin
        seg_q[i] <= SEG_ZERO;
      end
    end else begin
      seg_q <= seg_next;
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule : hex_display

// File: src/board_ctrl_top.sv
// Single clock domain; run registers and display use arst_n while sys_rst_n only feeds the processor
module board_ctrl_top (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic [board_pkg::NUM_KEYS-1:0] key,
  input  logic [board_pkg::SW_W-1:0]     sw,
  input  logic                           pll_locked,
  output logic                           sys_rst_n,
  output logic                           go,
  output logic [board_pkg::SW_W-1:0]     boot_pc,
  output logic                           running,
  output logic [board_pkg::SEG_W-1:0]    hex0,
  output logic [board_pkg::SEG_W-1:0]    hex1,
  output logic [board_pkg::SEG_W-1:0]    hex2,
  output logic [board_pkg::SEG_W-1:0]    hex3,
  output logic [board_pkg::SEG_W-1:0]    hex4,
  output logic [board_pkg::SEG_W-1:0]    hex5
);
  import board_pkg::*;

  // Debounced keys read 0 when pressed
  logic [NUM_KEYS-1:0]  key_level;
  // Press strobes
  logic [NUM_KEYS-1:0]  key_fall;

  // Register block to display
  logic [RUN_CNT_W-1:0] run_count;
  logic [TIMER_W-1:0]   run_timer;
  logic                 disp_mode;

  // ========================================
  // Key conditioning
  // ========================================

  for (genvar k = 0; k < NUM_KEYS; k++) begin : g_key
    key_debouncer #(
      .CYCLES  (DBC_CYCLES)
    ) key_dbc_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .key_raw (key[k]),
      .level   (key_level[k]),
      .rise    (),
      .fall    (key_fall[k])
    );
  end

  // Button reset plus PLL lock
  reset_cond reset_cond_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .btn_level  (key_level[KEY_RESET]),
    .pll_locked (pll_locked),
    .sys_rst_n  (sys_rst_n)
  );

  // ========================================
  // Run control and display
  // ========================================

  // Presses are falls since keys are active low
  run_ctrl_regs run_ctrl_regs_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sw        (sw),
    .go_req    (key_fall[KEY_GO]),
    .stop_req  (key_fall[KEY_STOP]),
    .mode_req  (key_fall[KEY_MODE]),
    .go        (go),
    .running   (running),
    .boot_pc   (boot_pc),
    .run_count (run_count),
    .run_timer (run_timer),
    .disp_mode (disp_mode)
  );

  hex_display hex_display_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .disp_mode (disp_mode),
    .running   (running),
    .boot_pc   (boot_pc),
    .run_count (run_count),
    .run_timer (run_timer),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5)
  );

endmodule : board_ctrl_top

// File: dv/board_ctrl_properties.sv
// Bound into board_ctrl_top; all checks are off while arst_n is low
module board_ctrl_properties (
  input logic clk,
  input logic arst_n,
  input logic go,
  input logic running,
  input logic sys_rst_n,
  input logic pll_locked
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failure tally for the testbench summary
  int unsigned assert_fails = 0;

  // Start strobe lasts one cycle
  a_go_single : assert property (@(posedge clk) disable iff (!arst_n) go |=> !go)
    else begin
      assert_fails++;
      $error("go high for two consecutive cycles");
    end

  // Lock loss asserts system reset on the next edge
  a_lock_reset : assert property (@(posedge clk) disable iff (!arst_n)
                                  !pll_locked |=> !sys_rst_n)
    else begin
      assert_fails++;
      $error("sys_rst_n high one cycle after pll_locked low");
    end

  // Running and go are set by the same edge
  a_run_start : assert property (@(posedge clk) disable iff (!arst_n) $rose(running) |-> go)
    else begin
      assert_fails++;
      $error("running rose without a go pulse");
    end

endmodule : board_ctrl_properties

bind board_ctrl_top board_ctrl_properties props_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .go         (go),
  .running    (running),
  .sys_rst_n  (sys_rst_n),
  .pll_locked (pll_locked)
);

// File: dv/board_ctrl_tb.sv
// Directed testbench for board_ctrl_top; waits scale with DBC_CYCLES and count wrap is modelled only
module board_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import board_pkg::*;

  // One press is a hold plus a release of equal length
  localparam int unsigned PRESS_LEN      = 2 * (DBC_CYCLES + 6);
  // Six presses, bounce runs, reset waits and gaps
  localparam int unsigned TEST_CYCLES    = 16 * PRESS_LEN + 600;
  localparam int unsigned TIMEOUT_CYCLES = 4 * TEST_CYCLES;
  // Lower case r lights e and g while blank lights nothing
  localparam logic [SEG_W-1:0] LETTER_R = ~7'h50;
  localparam logic [SEG_W-1:0] SEG_OFF  = 7'h7F;

  logic                clk = 1'b0;
  logic                arst_n;
  logic [NUM_KEYS-1:0] key;
  logic [SW_W-1:0]     sw;
  logic                pll_locked;
  logic                sys_rst_n;
  logic                go;
  logic                running;
  logic [SW_W-1:0]     boot_pc;
  logic [SEG_W-1:0]    hex0;
  logic [SEG_W-1:0]    hex1;
  logic [SEG_W-1:0]    hex2;
  logic [SEG_W-1:0]    hex3;
  logic [SEG_W-1:0]    hex4;
  logic [SEG_W-1:0]    hex5;

  // Reference model of the run registers
  logic [SW_W-1:0]      exp_pc;
  logic [RUN_CNT_W-1:0] exp_count;
  logic                 exp_running;

  logic [31:0] rng_state = 32'h248b1a94;
  int unsigned cycle_cnt = 0;
  int unsigned go_pulses = 0;
  int unsigned go_cycle  = 0;
  int unsigned err_cnt   = 0;
  int unsigned check_cnt = 0;
  int unsigned test_cnt  = 0;
  int unsigned test_bad  = 0;
  int unsigned test_err_start;

  board_ctrl_top dut_i (
    .clk(clk), .arst_n(arst_n), .key(key), .sw(sw), .pll_locked(pll_locked),
    .sys_rst_n(sys_rst_n), .go(go), .boot_pc(boot_pc), .running(running),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
  );

  // ========================================
  // Clock, watchdog, go monitor
  // ========================================

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  // Sampled mid-cycle away from the edge
  always @(negedge clk) begin
    if (go) begin
      go_pulses <= go_pulses + 1;
      go_cycle  <= cycle_cnt;
    end
  end

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lit segments per digit with bit 0 as a and inverted for active low
  function automatic logic [SEG_W-1:0] seg_of(input logic [3:0] nib);
    logic [SEG_W-1:0] lit;
    case (nib)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  // Bit 4 set when the pattern is no hex digit
  function automatic logic [4:0] nib_of(input logic [SEG_W-1:0] seg);
    logic [4:0] res;
    res = 5'h10;
    for (int n = 0; n < 16; n++) begin
      if (seg_of(4'(n)) == seg) begin
        res = {1'b0, 4'(n)};
      end
    end
    return res;
  endfunction

  // Step n edges and land 2 ns past the last one
  task automatic tick(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic report_error(input string text);
    err_cnt++;
    $display("Error at %0t: %s", $time, text);
  endtask

  task automatic check_seg(input string name, input logic [SEG_W-1:0] want,
                           input logic [SEG_W-1:0] got);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, want, got);
    end
  endtask

  task automatic check_pc(input string name, input logic [SW_W-1:0] want,
                          input logic [SW_W-1:0] got);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected 0x%h actual 0x%h", $time, name, want, got);
    end
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, want, got);
    end
  endtask

  task automatic check_count(input string name, input logic [RUN_CNT_W-1:0] want,
                             input logic [RUN_CNT_W-1:0] got);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, want, got);
    end
  endtask

  task automatic check_timer(input string name, input logic [TIMER_W-1:0] want,
                             input logic [TIMER_W-1:0] got);
    check_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected 0x%h actual 0x%h", $time, name, want, got);
    end
  endtask

  // PC mode picture of the model state
  task automatic check_display();
    logic [11:0] pc12;
    pc12 = 12'(exp_pc);
    check_seg("hex0", seg_of(pc12[3:0]), hex0);
    check_seg("hex1", seg_of(pc12[7:4]), hex1);
    check_seg("hex2", seg_of(pc12[11:8]), hex2);
    check_seg("hex3", exp_running ? LETTER_R : SEG_OFF, hex3);
    check_seg("hex4", seg_of(exp_count[3:0]), hex4);
    check_seg("hex5", seg_of(exp_count[7:4]), hex5);
  endtask

  // Timer mode digits back to a number
  task automatic read_timer(output logic [TIMER_W-1:0] value, output bit valid);
    logic [4:0] d [NUM_DIGITS];
    d[0] = nib_of(hex0);
    d[1] = nib_of(hex1);
    d[2] = nib_of(hex2);
    d[3] = nib_of(hex3);
    d[4] = nib_of(hex4);
    d[5] = nib_of(hex5);
    valid = 1'b1;
    value = '0;
    for (int i = NUM_DIGITS - 1; i >= 0; i--) begin
      if (d[i][4]) begin
        valid = 1'b0;
      end
      value = {value[TIMER_W-5:0], d[i][3:0]};
    end
  endtask

  task automatic press_key(input int unsigned k);
    logic [NUM_KEYS-1:0] mask;
    mask = NUM_KEYS'(1) << k;
    key  = key & ~mask;
    tick(DBC_CYCLES + 6);
    key  = key | mask;
    tick(DBC_CYCLES + 6);
  endtask

  // Runs of 1 to DBC_CYCLES-1 cycles and then a settled release
  task automatic bounce_key(input int unsigned k, input int unsigned runs);
    logic [NUM_KEYS-1:0] mask;
    int unsigned         len;
    mask = NUM_KEYS'(1) << k;
    for (int unsigned i = 0; i < runs; i++) begin
      rng_state = xorshift32(rng_state);
      len = (rng_state % (DBC_CYCLES - 1)) + 1;
      key = key ^ mask;
      tick(len);
    end
    key = key | mask;
    tick(DBC_CYCLES + 6);
  endtask

  task automatic wait_sys_rst(input logic want, input int unsigned limit, output bit seen);
    int unsigned n;
    n    = 0;
    seen = (sys_rst_n === want);
    while (!seen && n < limit) begin
      tick(1);
      n++;
      seen = (sys_rst_n === want);
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_start) begin
      $display("Test %s: ok", name);
    end else begin
      test_bad++;
      $display("Test %s: %0d errors", name, err_cnt - test_err_start);
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================

  task automatic test_after_reset();
    bit seen;
    test_err_start = err_cnt;
    tick(3);
    // Reset values of the digits
    check_seg("hex0", seg_of(4'h0), hex0);
    check_seg("hex1", seg_of(4'h0), hex1);
    check_seg("hex2", seg_of(4'h0), hex2);
    check_seg("hex3", seg_of(4'h0), hex3);
    check_seg("hex4", seg_of(4'h0), hex4);
    check_seg("hex5", seg_of(4'h0), hex5);
    check_bit("sys_rst_n", 1'b0, sys_rst_n);
    arst_n = 1'b1;
    wait_sys_rst(1'b1, 4, seen);
    if (!seen) begin
      report_error("sys_rst_n did not release after reset with PLL locked");
    end
    check_bit("running", 1'b0, running);
    check_bit("go", 1'b0, go);
    check_pc("boot_pc", exp_pc, boot_pc);
    check_display();
    end_test("after_reset");
  endtask

  task automatic test_go_capture(input int unsigned presses);
    int unsigned pulses_before;
    logic [4:0]  cnt_hi;
    logic [4:0]  cnt_lo;
    test_err_start = err_cnt;
    for (int unsigned p = 0; p < presses; p++) begin
      rng_state = xorshift32(rng_state);
      sw = SW_W'(rng_state);
      pulses_before = go_pulses;
      press_key(KEY_GO);
      exp_pc      = sw;
      exp_count   = exp_count + 1'b1;
      exp_running = 1'b1;
      if (go_pulses - pulses_before != 1) begin
        report_error($sformatf("go pulsed %0d times for one press", go_pulses - pulses_before));
      end
      check_pc("boot_pc", exp_pc, boot_pc);
      check_bit("running", exp_running, running);
      cnt_hi = nib_of(hex5);
      cnt_lo = nib_of(hex4);
      check_count("run_count digits", exp_count, {cnt_hi[3:0], cnt_lo[3:0]});
      check_display();
    end
    end_test("go_capture");
  endtask

  task automatic test_bounce();
    int unsigned pulses_before;
    test_err_start = err_cnt;
    // A wrong capture would show up as a new PC
    sw = ~exp_pc;
    pulses_before = go_pulses;
    rng_state = xorshift32(rng_state);
    bounce_key(KEY_GO, 4 + (rng_state % 5));
    if (go_pulses != pulses_before) begin
      report_error("bounces on the go key produced a go pulse");
    end
    check_pc("boot_pc", exp_pc, boot_pc);
    check_bit("running", exp_running, running);
    check_display();
    end_test("bounce_reject");
  endtask

  task automatic test_stop_timer();
    logic [TIMER_W-1:0] t_first;
    logic [TIMER_W-1:0] t_later;
    bit                 ok_first;
    bit                 ok_later;
    int unsigned        since_go;
    test_err_start = err_cnt;
    press_key(KEY_STOP);
    exp_running = 1'b0;
    check_bit("running", exp_running, running);
    check_display();
    press_key(KEY_MODE);
    read_timer(t_first, ok_first);
    tick(5);
    read_timer(t_later, ok_later);
    since_go = cycle_cnt - go_cycle;
    if (!ok_first || !ok_later) begin
      report_error("timer mode digits are not hex patterns");
    end
    check_timer("run_timer digits", t_first, t_later);
    if (t_first == '0) begin
      report_error("timer shows zero after a run");
    end
    if (32'(t_first) >= since_go) begin
      report_error($sformatf("timer %0d not below %0d cycles since go", t_first, since_go));
    end
    // Back to PC mode
    press_key(KEY_MODE);
    check_display();
    end_test("stop_timer");
  endtask

  task automatic test_reset_cond();
    bit                  seen;
    logic [NUM_KEYS-1:0] mask;
    test_err_start = err_cnt;
    mask = NUM_KEYS'(1) << KEY_RESET;
    pll_locked = 1'b0;
    tick(1);
    check_bit("sys_rst_n", 1'b0, sys_rst_n);
    tick(2);
    pll_locked = 1'b1;
    wait_sys_rst(1'b1, DBC_CYCLES + 6, seen);
    if (!seen) begin
      report_error("sys_rst_n stayed low after PLL lock returned");
    end
    key = key & ~mask;
    wait_sys_rst(1'b0, DBC_CYCLES + 6, seen);
    if (!seen) begin
      report_error("reset key press did not assert sys_rst_n");
    end
    tick(4);
    key = key | mask;
    wait_sys_rst(1'b1, DBC_CYCLES + 6, seen);
    if (!seen) begin
      report_error("sys_rst_n stayed low after reset key release");
    end
    check_pc("boot_pc", exp_pc, boot_pc);
    check_bit("running", exp_running, running);
    check_display();
    end_test("reset_cond");
  endtask

  // ========================================
  // Sequence
  // ========================================

  initial begin
    arst_n      = 1'b0;
    key         = '1;
    sw          = '0;
    pll_locked  = 1'b1;
    exp_pc      = '0;
    exp_count   = '0;
    exp_running = 1'b0;
    test_after_reset();
    test_go_capture(3);
    test_bounce();
    test_stop_timer();
    test_reset_cond();
    if (dut_i.props_i.assert_fails != 0) begin
      report_error($sformatf("%0d assertion failures", dut_i.props_i.assert_fails));
    end
    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             test_cnt, test_bad, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : board_ctrl_tb

// File: sim.f
src/board_pkg.sv
src/key_debouncer.sv
src/reset_cond.sv
src/run_ctrl_regs.sv
src/hex_display.sv
src/board_ctrl_top.sv
dv/board_ctrl_properties.sv
dv/board_ctrl_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module board_ctrl_top \
		src/board_pkg.sv src/key_debouncer.sv src/reset_cond.sv \
		src/run_ctrl_regs.sv src/hex_display.sv src/board_ctrl_top.sv
	verilator --lint-only --timing --assert --top-module board_ctrl_tb -f sim.f

sim:
	verilator --binary --timing --assert --top-module board_ctrl_tb \
		-Mdir obj_dir -o board_ctrl_sim -f sim.f
	obj_dir/board_ctrl_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
